// File: rtl/rename_pkg.sv
package rename_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// sizes.
	localparam int issue_width = 3;
	localparam int arch_regs = 32;
	localparam int phys_regs = 64;
	localparam int fl_depth = 32;
	localparam int rob_depth = 16;

	typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;
	typedef logic [$clog2(phys_regs)-1:0] phys_tag_t;
	typedef logic [$clog2(fl_depth)-1:0] fl_ptr_t;
	typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

	typedef enum logic [1:0] {
		OP_ALU,
		OP_LOAD,
		OP_STORE,
		OP_BRANCH
	} op_kind_e;

	typedef enum logic {
		CKPT_IDLE,
		CKPT_HELD
	} ckpt_state_e;

	// ~~~~~~~~~~~~~~~~~~~~
	// operation records.
	typedef struct packed {
		logic valid;
		op_kind_e kind;
		arch_reg_t dest;
		arch_reg_t src1;
		arch_reg_t src2;
	} dispatch_op_t;

	typedef struct packed {
		logic valid;
		op_kind_e kind;
		arch_reg_t dest;
		phys_tag_t src1_tag;
		phys_tag_t src2_tag;
		phys_tag_t dest_tag;
		phys_tag_t old_tag;
	} renamed_op_t;

	typedef struct packed {
		logic valid;
		op_kind_e kind;
		arch_reg_t dest;
		phys_tag_t dest_tag;
		phys_tag_t old_tag;
	} retire_op_t;

	// only alu and load results land in a register.
	function automatic logic writes_dest(input op_kind_e kind);
		return (kind == OP_ALU) || (kind == OP_LOAD);
	endfunction

endpackage

// File: rtl/free_list.sv
`timescale 1ns/100ps

module free_list (
	input  logic clock,
	input  logic reset,
	input  logic [rename_pkg::issue_width-1:0] alloc_mask,
	output rename_pkg::phys_tag_t [rename_pkg::issue_width-1:0] alloc_tags,
	input  logic [rename_pkg::issue_width-1:0] release_mask,
	input  rename_pkg::phys_tag_t [rename_pkg::issue_width-1:0] release_tags,
	input  logic ckpt_save,
	input  logic recover,
	output logic [5:0] free_count
);

	rename_pkg::phys_tag_t tags [rename_pkg::fl_depth];

	rename_pkg::fl_ptr_t head;
	rename_pkg::fl_ptr_t head_next;
	rename_pkg::fl_ptr_t tail;
	rename_pkg::fl_ptr_t tail_next;
	rename_pkg::fl_ptr_t saved_head;
	rename_pkg::fl_ptr_t ptr_diff;
	rename_pkg::fl_ptr_t rel_slot [rename_pkg::issue_width];

	logic [1:0] n_alloc;
	logic [1:0] n_release;
	logic [5:0] count;
	logic [5:0] count_next;

	assign free_count = count;

	// ~~~~~~~~~~~~~~~~~~~~
	// allocation, lanes packed from the head.
	always_comb begin
		n_alloc = '0;
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			alloc_tags[k] = '0;
			if (alloc_mask[k]) begin
				alloc_tags[k] = tags[head + rename_pkg::fl_ptr_t'(n_alloc)];
				n_alloc = n_alloc + 2'd1;
			end
		end
	end

	// releases close up the gaps between lanes at the tail.
	always_comb begin
		n_release = '0;
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			rel_slot[k] = tail + rename_pkg::fl_ptr_t'(n_release);
			if (release_mask[k]) begin
				n_release = n_release + 2'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy.
	always_comb begin
		head_next = head + rename_pkg::fl_ptr_t'(n_alloc);
		tail_next = tail + rename_pkg::fl_ptr_t'(n_release);
		ptr_diff = tail_next - saved_head;
		count_next = count - 6'(n_alloc) + 6'(n_release);
		if (recover) begin
			head_next = saved_head;
			// rewinding never empties the queue, so equal pointers mean full.
			count_next = (ptr_diff == '0) ? 6'(rename_pkg::fl_depth) : {1'b0, ptr_diff};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= 6'(rename_pkg::fl_depth);
			for (int i = 0; i < rename_pkg::fl_depth; i++) begin
				tags[i] <= rename_pkg::phys_tag_t'(i + rename_pkg::fl_depth);
			end
		end else begin
			head <= head_next;
			tail <= tail_next;
			count <= count_next;
			for (int k = 0; k < rename_pkg::issue_width; k++) begin
				if (release_mask[k]) begin
					tags[rel_slot[k]] <= release_tags[k];
				end
			end
		end
	end

	// head position just after the branch group.
	always_ff @(posedge clock) begin
		if (ckpt_save) begin
			saved_head <= head_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// checks.
	alloc_within_count: assert property (
		@(posedge clock) disable iff (reset)
		6'(n_alloc) <= count
	);

	count_bounded: assert property (
		@(posedge clock) disable iff (reset)
		count <= 6'(rename_pkg::fl_depth)
	);

endmodule

// File: rtl/rename_map.sv
`timescale 1ns/100ps

module rename_map (
	input  logic clock,
	input  logic reset,
	input  rename_pkg::dispatch_op_t [rename_pkg::issue_width-1:0] dispatch_ops,
	input  logic dispatch_valid,
	output logic dispatch_ready,
	input  logic [5:0] free_count,
	input  logic [4:0] rob_free,
	input  logic ckpt_held,
	input  logic branch_resolve,
	input  logic recover,
	output logic [rename_pkg::issue_width-1:0] alloc_mask,
	input  rename_pkg::phys_tag_t [rename_pkg::issue_width-1:0] alloc_tags,
	output logic ckpt_save,
	output rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] rob_write,
	output rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] renamed_ops
);

	rename_pkg::phys_tag_t map_table [rename_pkg::arch_regs];
	rename_pkg::phys_tag_t map_snap [rename_pkg::arch_regs];
	rename_pkg::phys_tag_t map_next [rename_pkg::arch_regs];

	logic [1:0] n_valid;
	logic [1:0] n_dest;
	logic has_branch;
	logic branch_last;
	logic accept;

	logic [rename_pkg::issue_width-1:0] out_valid;
	rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] out_ops;

	// ~~~~~~~~~~~~~~~~~~~~
	// group summary and acceptance.
	always_comb begin
		n_valid = '0;
		n_dest = '0;
		has_branch = 1'b0;
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			if (dispatch_ops[k].valid) begin
				n_valid = n_valid + 2'd1;
				if (rename_pkg::writes_dest(dispatch_ops[k].kind)) begin
					n_dest = n_dest + 2'd1;
				end
				if (dispatch_ops[k].kind == rename_pkg::OP_BRANCH) begin
					has_branch = 1'b1;
				end
			end
		end
	end

	// a valid lane right after a branch breaks the rule.
	always_comb begin
		branch_last = 1'b1;
		for (int k = 1; k < rename_pkg::issue_width; k++) begin
			if (dispatch_ops[k].valid && dispatch_ops[k-1].valid &&
					dispatch_ops[k-1].kind == rename_pkg::OP_BRANCH) begin
				branch_last = 1'b0;
			end
		end
	end

	assign dispatch_ready = (free_count >= 6'(n_dest)) && (rob_free >= 5'(n_valid)) &&
			!(has_branch && ckpt_held) && !branch_resolve;
	assign accept = dispatch_valid && dispatch_ready;
	assign ckpt_save = accept && has_branch;

	always_comb begin
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			alloc_mask[k] = accept && dispatch_ops[k].valid &&
					rename_pkg::writes_dest(dispatch_ops[k].kind);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// lookup in lane order; earlier lanes of the group update map_next first.
	always_comb begin
		map_next = map_table;
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			rob_write[k].valid = accept && dispatch_ops[k].valid;
			rob_write[k].kind = dispatch_ops[k].kind;
			rob_write[k].dest = dispatch_ops[k].dest;
			rob_write[k].src1_tag = map_next[dispatch_ops[k].src1];
			rob_write[k].src2_tag = map_next[dispatch_ops[k].src2];
			rob_write[k].old_tag = alloc_mask[k] ? map_next[dispatch_ops[k].dest] : '0;
			rob_write[k].dest_tag = alloc_mask[k] ? alloc_tags[k] : '0;
			if (alloc_mask[k]) begin
				map_next[dispatch_ops[k].dest] = alloc_tags[k];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_pkg::arch_regs; i++) begin
				map_table[i] <= rename_pkg::phys_tag_t'(i);
			end
		end else if (recover) begin
			map_table <= map_snap;
		end else begin
			map_table <= map_next;
		end
	end

	// snapshot includes the branch group itself.
	always_ff @(posedge clock) begin
		if (ckpt_save) begin
			map_snap <= map_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// renamed output register.
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= '0;
		end else begin
			for (int k = 0; k < rename_pkg::issue_width; k++) begin
				out_valid[k] <= rob_write[k].valid;
			end
		end
	end

	always_ff @(posedge clock) begin
		out_ops <= rob_write;
	end

	always_comb begin
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			renamed_ops[k] = out_ops[k];
			renamed_ops[k].valid = out_valid[k];
		end
	end

	branch_only_last: assert property (
		@(posedge clock) disable iff (reset)
		dispatch_valid |-> branch_last
	);

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer (
	input  logic clock,
	input  logic reset,
	input  rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] rob_write,
	input  logic [1:0] retire_request,
	input  logic branch_resolve,
	input  logic branch_mispredict,
	input  logic ckpt_save,
	output logic [4:0] rob_free,
	output logic ckpt_held,
	output logic recover,
	output logic [rename_pkg::issue_width-1:0] release_mask,
	output rename_pkg::phys_tag_t [rename_pkg::issue_width-1:0] release_tags,
	output rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] retire_ops
);

	rename_pkg::retire_op_t rob_mem [rename_pkg::rob_depth];

	rename_pkg::rob_idx_t head;
	rename_pkg::rob_idx_t head_next;
	rename_pkg::rob_idx_t tail;
	rename_pkg::rob_idx_t tail_next;
	rename_pkg::rob_idx_t saved_tail;
	rename_pkg::rob_idx_t br_idx;
	rename_pkg::rob_idx_t ptr_diff;

	logic [4:0] count;
	logic [4:0] count_next;
	logic [1:0] n_write;
	logic [1:0] n_avail;
	logic [1:0] n_retire;
	logic blocked;

	rename_pkg::ckpt_state_e state;
	rename_pkg::ckpt_state_e state_next;

	rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] retire_next;
	rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] ret_ops;
	logic [rename_pkg::issue_width-1:0] ret_valid;

	assign ckpt_held = (state == rename_pkg::CKPT_HELD);
	assign recover = ckpt_held && branch_resolve && branch_mispredict;
	// the branch is the last entry written before the saved tail.
	assign br_idx = saved_tail - 4'd1;
	assign rob_free = 5'(rename_pkg::rob_depth) - count;

	// ~~~~~~~~~~~~~~~~~~~~
	// retirement, oldest first, halted at the held branch.
	always_comb begin
		n_avail = '0;
		blocked = 1'b0;
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			if (5'(k) >= count) begin
				blocked = 1'b1;
			end
			if (ckpt_held && (head + rename_pkg::rob_idx_t'(k)) == br_idx) begin
				blocked = 1'b1;
			end
			if (!blocked) begin
				n_avail = n_avail + 2'd1;
			end
		end
		n_retire = (retire_request < n_avail) ? retire_request : n_avail;
	end

	always_comb begin
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			retire_next[k] = rob_mem[head + rename_pkg::rob_idx_t'(k)];
			retire_next[k].valid = 2'(k) < n_retire;
			release_mask[k] = retire_next[k].valid &&
					rename_pkg::writes_dest(retire_next[k].kind);
			release_tags[k] = retire_next[k].old_tag;
		end
	end

	always_comb begin
		n_write = '0;
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			if (rob_write[k].valid) begin
				n_write = n_write + 2'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// pointers; a mispredict drops everything past the branch group.
	always_comb begin
		head_next = head + rename_pkg::rob_idx_t'(n_retire);
		tail_next = tail + rename_pkg::rob_idx_t'(n_write);
		ptr_diff = saved_tail - head_next;
		count_next = count + 5'(n_write) - 5'(n_retire);
		if (recover) begin
			tail_next = saved_tail;
			// the branch itself stays, so equal pointers mean full.
			count_next = (ptr_diff == '0) ? 5'(rename_pkg::rob_depth) : {1'b0, ptr_diff};
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			rename_pkg::CKPT_IDLE: if (ckpt_save) state_next = rename_pkg::CKPT_HELD;
			rename_pkg::CKPT_HELD: if (branch_resolve) state_next = rename_pkg::CKPT_IDLE;
			default: state_next = rename_pkg::CKPT_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			state <= rename_pkg::CKPT_IDLE;
			ret_valid <= '0;
		end else begin
			head <= head_next;
			tail <= tail_next;
			count <= count_next;
			state <= state_next;
			for (int k = 0; k < rename_pkg::issue_width; k++) begin
				ret_valid[k] <= retire_next[k].valid;
			end
		end
	end

	always_ff @(posedge clock) begin
		ret_ops <= retire_next;
		if (ckpt_save) begin
			saved_tail <= tail_next;
		end
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			if (rob_write[k].valid) begin
				rob_mem[tail + rename_pkg::rob_idx_t'(k)] <= '{
					valid: 1'b1,
					kind: rob_write[k].kind,
					dest: rob_write[k].dest,
					dest_tag: rob_write[k].dest_tag,
					old_tag: rob_write[k].old_tag
				};
			end
		end
	end

	always_comb begin
		for (int k = 0; k < rename_pkg::issue_width; k++) begin
			retire_ops[k] = ret_ops[k];
			retire_ops[k].valid = ret_valid[k];
		end
	end

	no_stray_resolve: assert property (
		@(posedge clock) disable iff (reset)
		branch_resolve |-> ckpt_held
	);

endmodule

// File: rtl/rename_core.sv
`timescale 1ns/100ps

module rename_core (
	input  logic clock,
	input  logic reset,
	input  rename_pkg::dispatch_op_t [rename_pkg::issue_width-1:0] dispatch_ops,
	input  logic dispatch_valid,
	output logic dispatch_ready,
	input  logic [1:0] retire_request,
	input  logic branch_resolve,
	input  logic branch_mispredict,
	output rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] renamed_ops,
	output rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] retire_ops,
	output logic [5:0] free_count
);

	logic [rename_pkg::issue_width-1:0] alloc_mask;
	rename_pkg::phys_tag_t [rename_pkg::issue_width-1:0] alloc_tags;
	logic [rename_pkg::issue_width-1:0] release_mask;
	rename_pkg::phys_tag_t [rename_pkg::issue_width-1:0] release_tags;
	rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] rob_write;
	logic [4:0] rob_free;
	logic ckpt_save;
	logic ckpt_held;
	logic recover;

	// ~~~~~~~~~~~~~~~~~~~~
	// producer.
	rename_map u_rename_map (
		.clock          (clock),
		.reset          (reset),
		.dispatch_ops   (dispatch_ops),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.free_count     (free_count),
		.rob_free       (rob_free),
		.ckpt_held      (ckpt_held),
		.branch_resolve (branch_resolve),
		.recover        (recover),
		.alloc_mask     (alloc_mask),
		.alloc_tags     (alloc_tags),
		.ckpt_save      (ckpt_save),
		.rob_write      (rob_write),
		.renamed_ops    (renamed_ops)
	);

	// tag queue.
	free_list u_free_list (
		.clock        (clock),
		.reset        (reset),
		.alloc_mask   (alloc_mask),
		.alloc_tags   (alloc_tags),
		.release_mask (release_mask),
		.release_tags (release_tags),
		.ckpt_save    (ckpt_save),
		.recover      (recover),
		.free_count   (free_count)
	);

	// consumer.
	reorder_buffer u_reorder_buffer (
		.clock             (clock),
		.reset             (reset),
		.rob_write         (rob_write),
		.retire_request    (retire_request),
		.branch_resolve    (branch_resolve),
		.branch_mispredict (branch_mispredict),
		.ckpt_save         (ckpt_save),
		.rob_free          (rob_free),
		.ckpt_held         (ckpt_held),
		.recover           (recover),
		.release_mask      (release_mask),
		.release_tags      (release_tags),
		.retire_ops        (retire_ops)
	);

endmodule

// File: tests/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// model state.
rename_pkg::phys_tag_t model_map [rename_pkg::arch_regs];
rename_pkg::phys_tag_t model_snap [rename_pkg::arch_regs];
rename_pkg::phys_tag_t model_free [$];
// tags handed out after the branch group, returned to the head on a mispredict.
rename_pkg::phys_tag_t model_spec [$];
rename_pkg::retire_op_t model_rob [$];
bit model_held;
// entries written after the branch group.
int model_young;

function automatic bit has_result(input rename_pkg::op_kind_e kind);
	return (kind == rename_pkg::OP_ALU) || (kind == rename_pkg::OP_LOAD);
endfunction

task automatic reset_model();
	model_free.delete();
	model_spec.delete();
	model_rob.delete();
	for (int i = 0; i < rename_pkg::arch_regs; i++) begin
		model_map[i] = rename_pkg::phys_tag_t'(i);
	end
	for (int i = 0; i < rename_pkg::fl_depth; i++) begin
		model_free.push_back(rename_pkg::phys_tag_t'(i + rename_pkg::fl_depth));
	end
	model_snap = model_map;
	model_held = 1'b0;
	model_young = 0;
endtask

function automatic bit group_fits(
	input rename_pkg::dispatch_op_t [rename_pkg::issue_width-1:0] ops,
	input bit resolve
);
	int n_valid;
	int n_dest;
	bit branch;
	n_valid = 0;
	n_dest = 0;
	branch = 1'b0;
	for (int k = 0; k < rename_pkg::issue_width; k++) begin
		if (ops[k].valid) begin
			n_valid++;
			if (has_result(ops[k].kind)) n_dest++;
			if (ops[k].kind == rename_pkg::OP_BRANCH) branch = 1'b1;
		end
	end
	return (n_dest <= model_free.size()) &&
			(n_valid <= rename_pkg::rob_depth - model_rob.size()) &&
			!(branch && model_held) && !resolve;
endfunction

// oldest entries that may leave, stopping at a held branch.
function automatic int retire_limit(input int request);
	int avail;
	avail = (model_rob.size() < rename_pkg::issue_width) ? model_rob.size() : rename_pkg::issue_width;
	if (model_held && avail > model_rob.size() - 1 - model_young) begin
		avail = model_rob.size() - 1 - model_young;
	end
	return (request < avail) ? request : avail;
endfunction

task automatic retire_oldest(
	input int n,
	output rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] expected
);
	expected = '0;
	for (int k = 0; k < n; k++) begin
		expected[k] = model_rob.pop_front();
		if (has_result(expected[k].kind)) model_free.push_back(expected[k].old_tag);
	end
endtask

task automatic rename_group(
	input rename_pkg::dispatch_op_t [rename_pkg::issue_width-1:0] ops,
	output rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] expected
);
	bit branch;
	branch = 1'b0;
	expected = '0;
	for (int k = 0; k < rename_pkg::issue_width; k++) begin
		if (ops[k].valid) begin
			expected[k].valid = 1'b1;
			expected[k].kind = ops[k].kind;
			expected[k].dest = ops[k].dest;
			expected[k].src1_tag = model_map[ops[k].src1];
			expected[k].src2_tag = model_map[ops[k].src2];
			if (has_result(ops[k].kind)) begin
				expected[k].dest_tag = model_free.pop_front();
				expected[k].old_tag = model_map[ops[k].dest];
				model_map[ops[k].dest] = expected[k].dest_tag;
				if (model_held) model_spec.push_back(expected[k].dest_tag);
			end
			model_rob.push_back('{valid: 1'b1, kind: ops[k].kind, dest: ops[k].dest,
					dest_tag: expected[k].dest_tag, old_tag: expected[k].old_tag});
			if (model_held) model_young++;
			if (ops[k].kind == rename_pkg::OP_BRANCH) branch = 1'b1;
		end
	end
	if (branch) begin
		model_snap = model_map;
		model_held = 1'b1;
		model_spec.delete();
		model_young = 0;
	end
endtask

task automatic resolve_branch(input bit mispredict);
	if (mispredict) begin
		repeat (model_young) void'(model_rob.pop_back());
		for (int i = model_spec.size() - 1; i >= 0; i--) begin
			model_free.push_front(model_spec[i]);
		end
		model_map = model_snap;
	end
	model_spec.delete();
	model_young = 0;
	model_held = 1'b0;
endtask

`endif

// File: tests/rename_tb.sv
`timescale 1ns/100ps

module rename_tb;

	logic clock;
	logic reset;
	rename_pkg::dispatch_op_t [rename_pkg::issue_width-1:0] dispatch_ops;
	logic dispatch_valid;
	logic dispatch_ready;
	logic [1:0] retire_request;
	logic branch_resolve;
	logic branch_mispredict;
	rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] renamed_ops;
	rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] retire_ops;
	logic [5:0] free_count;

	rename_pkg::renamed_op_t [rename_pkg::issue_width-1:0] exp_renamed;
	rename_pkg::retire_op_t [rename_pkg::issue_width-1:0] exp_retired;
	int accepted;
	int mispredicts;
	int stall;

	`include "rename_model.svh"

	rename_core u_rename_core (
		.clock             (clock),
		.reset             (reset),
		.dispatch_ops      (dispatch_ops),
		.dispatch_valid    (dispatch_valid),
		.dispatch_ready    (dispatch_ready),
		.retire_request    (retire_request),
		.branch_resolve    (branch_resolve),
		.branch_mispredict (branch_mispredict),
		.renamed_ops       (renamed_ops),
		.retire_ops        (retire_ops),
		.free_count        (free_count)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// compare tasks.
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_renamed(input string name, input rename_pkg::renamed_op_t expected,
			input rename_pkg::renamed_op_t actual);
		if (expected.valid ? (actual !== expected) : (actual.valid !== 1'b0)) begin
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_retired(input string name, input rename_pkg::retire_op_t expected,
			input rename_pkg::retire_op_t actual);
		if (expected.valid ? (actual !== expected) : (actual.valid !== 1'b0)) begin
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input logic [5:0] expected,
			input logic [5:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_ready(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
		end
	endtask

	// one to three packed lanes, a branch only in the last one.
	task automatic make_group();
		int n;
		n = 1 + ($urandom % 3);
		dispatch_ops = '0;
		for (int k = 0; k < n; k++) begin
			dispatch_ops[k].valid = 1'b1;
			dispatch_ops[k].kind = rename_pkg::op_kind_e'($urandom % 4);
			if (dispatch_ops[k].kind == rename_pkg::OP_BRANCH && k != n - 1) begin
				dispatch_ops[k].kind = rename_pkg::op_kind_e'($urandom % 3);
			end
			dispatch_ops[k].dest = rename_pkg::arch_reg_t'($urandom);
			dispatch_ops[k].src1 = rename_pkg::arch_reg_t'($urandom);
			dispatch_ops[k].src2 = rename_pkg::arch_reg_t'($urandom);
		end
	endtask

	task automatic wait_ready(input int limit);
		int waited;
		waited = 0;
		while (dispatch_ready !== 1'b1) begin
			@(negedge clock);
			waited++;
			if (waited > limit) abort_run("dispatch_ready never rose after reset");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus and checking, one step per clock.
	initial begin
		bit pending;
		bit fits;
		void'($urandom(32'h8638_4b2c));
		reset = 1'b1;
		dispatch_ops = '0;
		dispatch_valid = 1'b0;
		retire_request = '0;
		branch_resolve = 1'b0;
		branch_mispredict = 1'b0;
		accepted = 0;
		mispredicts = 0;
		stall = 0;
		pending = 1'b0;
		exp_renamed = '0;
		exp_retired = '0;
		reset_model();
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		wait_ready(20);
		for (int cycle = 0; cycle < 4000; cycle++) begin
			@(negedge clock);
			for (int k = 0; k < rename_pkg::issue_width; k++) begin
				check_renamed($sformatf("cycle %0d renamed lane %0d", cycle, k),
						exp_renamed[k], renamed_ops[k]);
				check_retired($sformatf("cycle %0d retired lane %0d", cycle, k),
						exp_retired[k], retire_ops[k]);
			end
			check_count($sformatf("cycle %0d free count", cycle), 6'(model_free.size()), free_count);
			if (!pending) begin
				dispatch_ops = '0;
				if ($urandom % 4 != 0) begin
					make_group();
					pending = 1'b1;
					stall = 0;
				end
			end
			dispatch_valid = pending;
			retire_request = 2'($urandom);
			branch_resolve = model_held && ($urandom % 4 == 0);
			branch_mispredict = 1'($urandom);
			#1;
			fits = group_fits(dispatch_ops, branch_resolve);
			check_ready($sformatf("cycle %0d dispatch ready", cycle), fits, dispatch_ready);
			// retirement sees the checkpoint as it was before this edge.
			retire_oldest(retire_limit(retire_request), exp_retired);
			if (branch_resolve) begin
				if (branch_mispredict) mispredicts++;
				resolve_branch(branch_mispredict);
			end
			exp_renamed = '0;
			if (pending && fits) begin
				rename_group(dispatch_ops, exp_renamed);
				pending = 1'b0;
				accepted++;
			end else if (pending) begin
				stall++;
				if (stall > 200) abort_run("a dispatch group waited too long for acceptance");
			end
		end
		if (accepted == 0 || mispredicts == 0) begin
			$display("the run accepted no group or saw no mispredict");
			$display("Test FAILED");
			$fatal(1, "stimulus did not cover recovery");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: rename.f
+incdir+tests
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/rename_map.sv
rtl/reorder_buffer.sv
rtl/rename_core.sv
tests/rename_tb.sv

// File: Makefile
# Verilator build and run of the rename testbench.

SIM := obj_dir/Vrename_tb
SRCS := $(wildcard rtl/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(SIM)

# the binary is rebuilt only when a source or the file list changes.
$(SIM): rename.f $(SRCS)
	verilator --binary --timing -j 0 --top-module rename_tb -f rename.f -o Vrename_tb

# exit status of the simulator is the test result.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
